//--- common/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

    //////////////////////////////////////////////////
    // AXI bus widths
    //////////////////////////////////////////////////
    parameter int AXI_ADDR_W = 29;              // Read address
    parameter int AXI_LEN_W  = 8;               // Beats minus one
    parameter int AXI_DATA_W = 64;
    parameter int AXI_ID_W   = 4;

    // One lookaside entry per ID
    parameter int N_TAGS = 2 ** AXI_ID_W;

    // Counter has to hold N_TAGS itself
    parameter int CNT_W = $clog2(N_TAGS) + 1;

    //////////////////////////////////////////////////
    // Fixed AR attributes
    //////////////////////////////////////////////////
    parameter logic [1:0] AR_BURST_INCR   = 2'b01;    // INCR bursts only
    parameter logic [2:0] AR_SIZE_8B      = 3'b011;   // 8 bytes per beat
    parameter logic [3:0] AR_CACHE_NORMAL = 4'b0011;  // Normal, non-cacheable, bufferable

    //////////////////////////////////////////////////
    // Field types
    //////////////////////////////////////////////////
    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_LEN_W-1:0]  axi_len_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;

endpackage

`default_nettype wire

//--- common/rd_event_if.sv
`timescale 1ns/100ps
`default_nettype none

interface rd_event_if import axi_bridge_pkg::*; #(
    parameter int NUM_CLIENTS = 4
) ();

    localparam int CLI_W = $clog2(NUM_CLIENTS);

    // Issue group, from the AR handshake
    logic             issue;          // One cycle per accepted address
    axi_id_t          issue_id;
    logic [CLI_W-1:0] issue_client;

    // Retire group, from the last R beat
    logic             retire;         // One cycle per burst
    logic [CLI_W-1:0] retire_client;

    modport arbiter (output issue, issue_id, issue_client);

    modport router (
        input  issue, issue_id, issue_client,
        output retire, retire_client
    );

    // Counter only watches
    modport counter (input issue, issue_id, issue_client, retire, retire_client);

endinterface

`default_nettype wire

//--- rtl/rd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rd_arbiter import axi_bridge_pkg::*; #(
    parameter int NUM_CLIENTS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // Client request side
    input  wire logic [NUM_CLIENTS-1:0] rd_req,
    input  axi_id_t                     rd_req_id [NUM_CLIENTS],
    input  axi_addr_t                   rd_addr   [NUM_CLIENTS],
    input  axi_len_t                    rd_len    [NUM_CLIENTS],
    output logic      [NUM_CLIENTS-1:0] rd_req_ack,
    // AR channel
    output logic                        axi_arvalid,
    input  wire logic                   axi_arready,
    output axi_id_t                     axi_arid,
    output axi_addr_t                   axi_araddr,
    output axi_len_t                    axi_arlen,
    // Issue events
    rd_event_if.arbiter                 ev
);

    localparam int CLI_W = $clog2(NUM_CLIENTS);

    localparam logic ST_IDLE  = 1'b0;
    localparam logic ST_GRANT = 1'b1;

    logic             state;
    logic [CLI_W-1:0] gnt;          // Registered grant index
    logic [CLI_W-1:0] last_gnt;     // Round-robin pointer
    logic [CLI_W-1:0] rr_pick;
    logic             ar_hs;

    //////////////////////////////////////////////////
    // Round-robin pick
    //////////////////////////////////////////////////
    // Walk backwards so the nearest client after last_gnt wins
    always_comb begin
        int idx;
        rr_pick = last_gnt;
        for (int i = NUM_CLIENTS; i >= 1; i--) begin
            idx = (int'(last_gnt) + i) % NUM_CLIENTS;
            if (rd_req[idx]) begin
                rr_pick = CLI_W'(idx);
            end
        end
    end

    //////////////////////////////////////////////////
    // Grant FSM
    //////////////////////////////////////////////////
    assign ar_hs = axi_arvalid && axi_arready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            gnt      <= '0;
            last_gnt <= CLI_W'(NUM_CLIENTS - 1);     // Client 0 goes first
        end else begin
            case (state)
                ST_IDLE: begin
                    if (|rd_req) begin
                        gnt   <= rr_pick;
                        state <= ST_GRANT;
                    end
                end
                default: begin
                    if (ar_hs) begin
                        last_gnt <= gnt;            // Advance pointer on accept
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // AR fields straight from the granted client, held by its rd_req
    assign axi_arvalid = (state == ST_GRANT);
    assign axi_arid    = rd_req_id[gnt];
    assign axi_araddr  = rd_addr[gnt];
    assign axi_arlen   = rd_len[gnt];

    // Ack pulse to the granted client only
    always_comb begin
        rd_req_ack = '0;
        if (ar_hs) begin
            rd_req_ack[gnt] = 1'b1;
        end
    end

    // Issue event for router and counter
    assign ev.issue        = ar_hs;
    assign ev.issue_id     = axi_arid;
    assign ev.issue_client = gnt;

endmodule

`default_nettype wire

//--- rtl/outstanding_counter.sv
`timescale 1ns/100ps
`default_nettype none

module outstanding_counter import axi_bridge_pkg::*; #(
    parameter int NUM_CLIENTS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    rd_event_if.counter                 ev,
    output logic      [NUM_CLIENTS-1:0] rd_in_prog
);

    logic [CNT_W-1:0] cnt     [NUM_CLIENTS];
    logic [CNT_W-1:0] cnt_nxt [NUM_CLIENTS];

    //////////////////////////////////////////////////
    // Next count per client
    //////////////////////////////////////////////////
    always_comb begin
        logic inc;
        logic dec;
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            inc = ev.issue && (int'(ev.issue_client) == c);
            dec = ev.retire && (int'(ev.retire_client) == c);
            cnt_nxt[c] = cnt[c];
            if (inc && !dec) begin
                cnt_nxt[c] = cnt[c] + 1'b1;
            end else if (dec && !inc) begin
                cnt_nxt[c] = cnt[c] - 1'b1;
            end
            // Both in one cycle leaves the count alone
        end
    end

    //////////////////////////////////////////////////
    // Counters and flags
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < NUM_CLIENTS; c++) begin
                cnt[c] <= '0;
            end
            rd_in_prog <= '0;
        end else begin
            for (int c = 0; c < NUM_CLIENTS; c++) begin
                cnt[c]        <= cnt_nxt[c];
                rd_in_prog[c] <= |cnt_nxt[c];   // Same edge as the count
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rd_return_router.sv
`timescale 1ns/100ps
`default_nettype none

module rd_return_router import axi_bridge_pkg::*; #(
    parameter int NUM_CLIENTS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // R channel
    input  axi_id_t                     axi_rid,
    input  wire logic                   axi_rvalid,
    input  wire logic                   axi_rlast,
    input  axi_data_t                   axi_rdata,
    output logic                        axi_rready,
    // Client return side
    output axi_data_t                   rd_data,        // Same word to every client
    output logic      [NUM_CLIENTS-1:0] rd_data_vld,
    input  wire logic [NUM_CLIENTS-1:0] rd_data_rdy,
    output logic      [NUM_CLIENTS-1:0] rd_cmpl,
    // Issue in, retire out
    rd_event_if.router                  ev
);

    localparam int CLI_W = $clog2(NUM_CLIENTS);

    //////////////////////////////////////////////////
    // Tag lookaside table
    //////////////////////////////////////////////////
    logic [CLI_W-1:0] tag_client [N_TAGS];   // Owner of each ID
    logic [N_TAGS-1:0] tag_vld;

    logic [CLI_W-1:0] own;        // Owner of current RID
    logic             hit;
    logic             r_hs;
    logic             last_hs;

    // Valid bit set on issue and cleared on the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_vld <= '0;
        end else begin
            if (last_hs) begin
                tag_vld[axi_rid] <= 1'b0;
            end
            // Issue after retire, so a reused ID stays live
            if (ev.issue) begin
                tag_vld[ev.issue_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ev.issue) begin
            tag_client[ev.issue_id] <= ev.issue_client;
        end
    end

    //////////////////////////////////////////////////
    // Beat steering, all combinational
    //////////////////////////////////////////////////
    assign own = tag_client[axi_rid];
    assign hit = tag_vld[axi_rid];

    // Owner's ready goes back as rready
    assign axi_rready = hit && rd_data_rdy[own];

    assign r_hs    = axi_rvalid && axi_rready;
    assign last_hs = r_hs && axi_rlast;

    assign rd_data = axi_rdata;

    always_comb begin
        rd_data_vld = '0;
        rd_cmpl     = '0;
        if (axi_rvalid && hit) begin
            rd_data_vld[own] = 1'b1;        // Valid for the owner only
        end
        if (last_hs) begin
            rd_cmpl[own] = 1'b1;            // Last beat accepted
        end
    end

    // Retire event on the last beat
    assign ev.retire        = last_hs;
    assign ev.retire_client = own;

endmodule

`default_nettype wire

//--- rtl/axi_rd_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_bridge import axi_bridge_pkg::*; #(
    parameter int NUM_CLIENTS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,

    //////////////////////////////////////////////////
    // AXI read address channel
    //////////////////////////////////////////////////
    input  wire logic                   axi_arready,
    output axi_id_t                     axi_arid,
    output axi_addr_t                   axi_araddr,
    output axi_len_t                    axi_arlen,
    output logic      [2:0]             axi_arsize,
    output logic      [1:0]             axi_arburst,
    output logic      [3:0]             axi_arcache,
    output logic                        axi_arvalid,

    //////////////////////////////////////////////////
    // AXI read data channel
    //////////////////////////////////////////////////
    input  axi_id_t                     axi_rid,
    input  wire logic                   axi_rvalid,
    input  axi_data_t                   axi_rdata,
    input  wire logic                   axi_rlast,
    output logic                        axi_rready,

    //////////////////////////////////////////////////
    // Client ports
    //////////////////////////////////////////////////
    input  wire logic [NUM_CLIENTS-1:0] rd_req,         // Held until ack
    input  axi_id_t                     rd_req_id [NUM_CLIENTS],
    input  axi_addr_t                   rd_addr   [NUM_CLIENTS],
    input  axi_len_t                    rd_len    [NUM_CLIENTS],
    output logic      [NUM_CLIENTS-1:0] rd_req_ack,
    output logic      [NUM_CLIENTS-1:0] rd_in_prog,
    output axi_data_t                   rd_data,
    output logic      [NUM_CLIENTS-1:0] rd_data_vld,
    input  wire logic [NUM_CLIENTS-1:0] rd_data_rdy,
    output logic      [NUM_CLIENTS-1:0] rd_cmpl
);

    // Fixed burst attributes
    assign axi_arsize  = AR_SIZE_8B;
    assign axi_arburst = AR_BURST_INCR;
    assign axi_arcache = AR_CACHE_NORMAL;

    // Issue and retire events between the three blocks
    rd_event_if #(.NUM_CLIENTS(NUM_CLIENTS)) rd_ev ();

    rd_arbiter #(.NUM_CLIENTS(NUM_CLIENTS)) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .rd_req      (rd_req),
        .rd_req_id   (rd_req_id),
        .rd_addr     (rd_addr),
        .rd_len      (rd_len),
        .rd_req_ack  (rd_req_ack),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_arid    (axi_arid),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .ev          (rd_ev.arbiter)
    );

    rd_return_router #(.NUM_CLIENTS(NUM_CLIENTS)) u_router (
        .clk         (clk),
        .rst         (rst),
        .axi_rid     (axi_rid),
        .axi_rvalid  (axi_rvalid),
        .axi_rlast   (axi_rlast),
        .axi_rdata   (axi_rdata),
        .axi_rready  (axi_rready),
        .rd_data     (rd_data),
        .rd_data_vld (rd_data_vld),
        .rd_data_rdy (rd_data_rdy),
        .rd_cmpl     (rd_cmpl),
        .ev          (rd_ev.router)
    );

    // In-progress flags from outstanding bursts
    outstanding_counter #(.NUM_CLIENTS(NUM_CLIENTS)) u_counter (
        .clk         (clk),
        .rst         (rst),
        .ev          (rd_ev.counter),
        .rd_in_prog  (rd_in_prog)
    );

endmodule

`default_nettype wire

//--- bench/axi_rd_bridge_sva.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_bridge_sva import axi_bridge_pkg::*; #(
    parameter int NUM_CLIENTS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   axi_arvalid,
    input  wire logic                   axi_arready,
    input  axi_id_t                     axi_arid,
    input  axi_addr_t                   axi_araddr,
    input  axi_len_t                    axi_arlen,
    input  wire logic [NUM_CLIENTS-1:0] rd_req,
    input  wire logic [NUM_CLIENTS-1:0] rd_req_ack,
    input  wire logic                   axi_rvalid,
    input  wire logic                   axi_rlast,
    input  wire logic                   axi_rready,
    input  axi_id_t                     axi_rid
);

    int fail_cnt = 0;   // Failed assertions so far

    logic [N_TAGS-1:0] live_id;     // Issued on AR, last beat not yet taken

    // Rebuilt from the AR and R handshakes alone
    always_ff @(posedge clk) begin
        if (rst) begin
            live_id <= '0;
        end else begin
            if (axi_rvalid && axi_rready && axi_rlast) begin
                live_id[axi_rid] <= 1'b0;
            end
            if (axi_arvalid && axi_arready) begin
                live_id[axi_arid] <= 1'b1;  // Reissued ID wins
            end
        end
    end

    // AR fields frozen while stalled
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_arid)
            && $stable(axi_araddr) && $stable(axi_arlen))
    else begin
        $error("AR fields changed under back-pressure");
        fail_cnt++;
    end

    // At most one ack, and only to a client holding its request
    ack_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(rd_req_ack) && ((rd_req_ack & ~rd_req) == '0))
    else begin
        $error("rd_req_ack not one-hot or sent to a client without a request");
        fail_cnt++;
    end

    // No ready toward an ID nobody issued
    rready_tag: assert property (@(posedge clk) disable iff (rst)
        axi_rready |-> live_id[axi_rid])
    else begin
        $error("rready high for an RID with no burst in flight");
        fail_cnt++;
    end

endmodule

bind axi_rd_bridge axi_rd_bridge_sva #(.NUM_CLIENTS(NUM_CLIENTS)) sva_i (
    .clk         (clk),
    .rst         (rst),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_arid    (axi_arid),
    .axi_araddr  (axi_araddr),
    .axi_arlen   (axi_arlen),
    .rd_req      (rd_req),
    .rd_req_ack  (rd_req_ack),
    .axi_rvalid  (axi_rvalid),
    .axi_rlast   (axi_rlast),
    .axi_rready  (axi_rready),
    .axi_rid     (axi_rid)
);

`default_nettype wire

//--- bench/tb_axi_rd_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_rd_bridge import axi_bridge_pkg::*; ();

    localparam int NUM_CLIENTS = 4;
    localparam int MAX_REQ     = 32;
    localparam int TIMEOUT     = 4000;          // Cycles for the whole run

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   axi_arready;
    axi_id_t                axi_arid;
    axi_addr_t              axi_araddr;
    axi_len_t               axi_arlen;
    logic [2:0]             axi_arsize;
    logic [1:0]             axi_arburst;
    logic [3:0]             axi_arcache;
    logic                   axi_arvalid;
    axi_id_t                axi_rid;
    logic                   axi_rvalid;
    axi_data_t              axi_rdata;
    logic                   axi_rlast;
    logic                   axi_rready;
    logic [NUM_CLIENTS-1:0] rd_req;
    axi_id_t                rd_req_id [NUM_CLIENTS];
    axi_addr_t              rd_addr   [NUM_CLIENTS];
    axi_len_t               rd_len    [NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0] rd_req_ack;
    logic [NUM_CLIENTS-1:0] rd_in_prog;
    axi_data_t              rd_data;
    logic [NUM_CLIENTS-1:0] rd_data_vld;
    logic [NUM_CLIENTS-1:0] rd_data_rdy;
    logic [NUM_CLIENTS-1:0] rd_cmpl;

    // Requests from the data file
    int        n_req;
    int        req_cli  [MAX_REQ];
    axi_id_t   req_id   [MAX_REQ];
    axi_addr_t req_addr [MAX_REQ];
    axi_len_t  req_len  [MAX_REQ];
    int        req_gap  [MAX_REQ];

    //////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////
    int                     next_line;
    int                     pend     [NUM_CLIENTS];    // Line held per client, -1 if none
    int                     rdy_wait [NUM_CLIENTS];    // Cycles of rdy low left
    int                     out_cnt  [NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0] req_q;
    logic [NUM_CLIENTS-1:0] exp_prog;
    int                     last_gnt;
    int                     burst_q [$];               // Accepted, data not yet sent
    int                     cur;                       // Burst on the R channel
    int                     beat;
    int                     done_cnt;

    always #4 clk = ~clk;

    axi_rd_bridge #(.NUM_CLIENTS(NUM_CLIENTS)) dut_i (.*);

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    // Beat k of a burst at A carries A + k
    function automatic axi_data_t beat_data(input int l, input int k);
        return AXI_DATA_W'(req_addr[l]) + AXI_DATA_W'(k);
    endfunction

    // First held request after the last grant
    function automatic int rr_next();
        int c;
        for (int i = 1; i <= NUM_CLIENTS; i++) begin
            c = (last_gnt + i) % NUM_CLIENTS;
            if (req_q[c]) return c;
        end
        return -1;
    endfunction

    task automatic read_requests();
        int          fd;
        int          cli;
        int          gap;
        logic [31:0] id;
        logic [31:0] addr;
        logic [31:0] len;
        string       line;
        fd = $fopen("bench/rd_testdata.txt", "r");
        if (fd == 0) abort_run("cannot open bench/rd_testdata.txt");
        n_req = 0;
        while (!$feof(fd) && n_req < MAX_REQ) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines do not scan
            if ($sscanf(line, "%d %h %h %h %d", cli, id, addr, len, gap) == 5) begin
                req_cli[n_req]  = cli;
                req_id[n_req]   = axi_id_t'(id);
                req_addr[n_req] = axi_addr_t'(addr);
                req_len[n_req]  = axi_len_t'(len);
                req_gap[n_req]  = gap;
                n_req++;
            end
        end
        $fclose(fd);
        if (n_req == 0) abort_run("data file holds no requests");
    endtask

    //////////////////////////////////////////////////
    // Rising edge: client and slave drive
    //////////////////////////////////////////////////
    task automatic drive_inputs();
        int c;
        // Next batch once every held request is acked
        if (req_q == '0) begin
            while (next_line < n_req && pend[req_cli[next_line]] < 0) begin
                c            = req_cli[next_line];
                pend[c]      = next_line;
                req_q[c]     = 1'b1;
                rd_req_id[c] <= req_id[next_line];
                rd_addr[c]   <= req_addr[next_line];
                rd_len[c]    <= req_len[next_line];
                next_line++;
            end
        end
        rd_req      <= req_q;
        axi_arready <= ($urandom % 3) != 0;    // Random address stalls
        for (int k = 0; k < NUM_CLIENTS; k++) begin
            rd_data_rdy[k] <= (rdy_wait[k] == 0);
            if (rdy_wait[k] > 0) rdy_wait[k]--;
        end
        // Newest pending burst returns first
        if (cur < 0 && burst_q.size() > 0) begin
            cur  = burst_q.pop_back();
            beat = 0;
        end
        if (cur >= 0) begin
            axi_rvalid <= 1'b1;
            axi_rid    <= req_id[cur];
            axi_rdata  <= beat_data(cur, beat);
            axi_rlast  <= (beat == int'(req_len[cur]));
        end else begin
            axi_rvalid <= 1'b0;
            axi_rlast  <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // Falling edge: sample and compare
    //////////////////////////////////////////////////
    task automatic sample_outputs();
        logic [NUM_CLIENTS-1:0] exp_ack;
        logic [NUM_CLIENTS-1:0] exp_vld;
        logic [NUM_CLIENTS-1:0] exp_cmpl;
        int                     g;
        int                     l;
        int                     own;
        exp_ack  = '0;
        exp_vld  = '0;
        exp_cmpl = '0;
        check("sva_failures", 64'(dut_i.sva_i.fail_cnt), 64'd0);
        check("rd_in_prog", 64'(rd_in_prog), 64'(exp_prog));
        if (axi_arvalid && axi_arready) begin
            g = rr_next();
            if (g < 0) abort_run("address issued while no request was held");
            l = pend[g];
            check("axi_arid", 64'(axi_arid), 64'(req_id[l]));
            check("axi_araddr", 64'(axi_araddr), 64'(req_addr[l]));
            check("axi_arlen", 64'(axi_arlen), 64'(req_len[l]));
            check("axi_arburst", 64'(axi_arburst), 64'd1);    // INCR
            check("axi_arsize", 64'(axi_arsize), 64'd3);      // 8 bytes
            check("axi_arcache", 64'(axi_arcache), 64'd3);
            exp_ack[g] = 1'b1;
            burst_q.push_back(l);
            out_cnt[g]++;
            req_q[g] = 1'b0;
            pend[g]  = -1;
            last_gnt = g;
        end
        check("rd_req_ack", 64'(rd_req_ack), 64'(exp_ack));
        if (axi_rvalid) begin
            own          = req_cli[cur];
            exp_vld[own] = 1'b1;
            check("rd_data", rd_data, beat_data(cur, beat));
            check("axi_rready", 64'(axi_rready), 64'(rd_data_rdy[own]));
            if (axi_rready) begin
                rdy_wait[own] = req_gap[cur];
                if (axi_rlast) begin
                    exp_cmpl[own] = 1'b1;
                    out_cnt[own]--;
                    done_cnt++;
                    cur = -1;
                end else begin
                    beat++;
                end
            end
        end
        check("rd_data_vld", 64'(rd_data_vld), 64'(exp_vld));
        check("rd_cmpl", 64'(rd_cmpl), 64'(exp_cmpl));
        for (int k = 0; k < NUM_CLIENTS; k++) begin
            exp_prog[k] = (out_cnt[k] != 0);    // Seen one cycle later
        end
    endtask

    initial begin
        int cyc;
        int tail;
        void'($urandom(32'hfc1b1117));
        rst         <= 1'b1;
        rd_req      <= '0;
        rd_data_rdy <= '1;
        axi_arready <= 1'b0;
        axi_rvalid  <= 1'b0;
        axi_rid     <= '0;
        axi_rdata   <= '0;
        axi_rlast   <= 1'b0;
        for (int k = 0; k < NUM_CLIENTS; k++) begin
            rd_req_id[k] <= '0;
            rd_addr[k]   <= '0;
            rd_len[k]    <= '0;
            pend[k]      = -1;
            rdy_wait[k]  = 0;
            out_cnt[k]   = 0;
        end
        req_q     = '0;
        exp_prog  = '0;
        last_gnt  = NUM_CLIENTS - 1;
        cur       = -1;
        beat      = 0;
        next_line = 0;
        done_cnt  = 0;
        read_requests();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Run until two quiet cycles after the last completion
        tail = 0;
        for (cyc = 0; cyc < TIMEOUT && tail < 3; cyc++) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            sample_outputs();
            if (done_cnt == n_req) tail++;
        end
        if (tail < 3) begin
            abort_run("timeout before every burst completed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/rd_testdata.txt
// client id addr len gap
// id addr len in hex and len counts beats minus one, gap is rdy low cycles after a beat
0 0 0001000 03 0
1 1 0002000 01 1
2 2 0003000 00 0
3 3 0004000 07 2
2 4 0005100 02 0
1 5 1ffffffc 03 3
3 6 0006000 00 1
0 7 0007000 05 0
0 8 0008000 01 0
0 9 0009000 02 1
3 a 000a000 04 0
1 b 000b000 00 2
2 c 000c000 0f 0
1 d 000d000 01 1
3 e 000e000 02 0
2 f 000f000 03 2

//--- filelist.f
common/axi_bridge_pkg.sv
common/rd_event_if.sv
rtl/rd_arbiter.sv
rtl/outstanding_counter.sv
rtl/rd_return_router.sv
rtl/axi_rd_bridge.sv
bench/axi_rd_bridge_sva.sv
bench/tb_axi_rd_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the read bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_axi_rd_bridge \
    -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^=== PASS ===$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
